// ==== verilog/dma_pkg.sv ====
// DMA target package with flit field layout, AHB request and response types
`default_nettype none

package dma_pkg;

  ////////////////////
  // Widths
  localparam int FLIT_WIDTH = 34;
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Header field positions below the flit kind
  localparam int KIND_MSB = FLIT_WIDTH - 1;
  localparam int KIND_LSB = FLIT_WIDTH - 2;
  localparam int DEST_MSB = 31;
  localparam int DEST_LSB = 27;
  localparam int CLASS_MSB = 26;
  localparam int CLASS_LSB = 24;
  localparam int ID_MSB = 23;
  localparam int ID_LSB = 20;
  localparam int SRC_MSB = 19;
  localparam int SRC_LSB = 15;
  localparam int TYPE_MSB = 14;
  localparam int TYPE_LSB = 13;
  localparam int REQ_LAST_BIT = 12;

  ////////////////////
  // Field types
  typedef logic [FLIT_WIDTH-1:0] flit_t;
  typedef logic [4:0] tile_t;
  typedef logic [3:0] packet_id_t;
  typedef logic [2:0] packet_class_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // NoC class used by DMA traffic
  localparam packet_class_t CLASS_DMA = 3'd2;

  // AHB transfer types for single transfers
  localparam logic [1:0] HTRANS_IDLE = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  typedef enum logic [1:0] {
    PAYLOAD = 2'd0,
    HEADER  = 2'd1,
    LAST    = 2'd2,
    SINGLE  = 2'd3
  } flit_kind_t;

  typedef enum logic [1:0] {
    L2R_REQ  = 2'd0,
    L2R_RESP = 2'd1,
    R2L_REQ  = 2'd2,
    R2L_RESP = 2'd3
  } packet_type_t;

  typedef enum logic [1:0] {
    IDLE,
    GET_ADDR,
    WRITE,
    DISCARD
  } ctrl_state_t;

  ////////////////////
  // Bundles
  typedef struct packed {
    logic       sel;
    logic       write;
    logic [1:0] trans;
    addr_t      addr;
    data_t      wdata;
  } ahb_req_t;

  typedef struct packed {
    tile_t      dest;
    packet_id_t id;
  } resp_info_t;

  // True for the flit that closes a packet
  function automatic logic flit_is_end(flit_t f);
    flit_kind_t kind;
    kind = flit_kind_t'(f[KIND_MSB:KIND_LSB]);
    return (kind == LAST) || (kind == SINGLE);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/dma_packet_buffer.sv ====
// Store-and-forward flit FIFO that only releases fully received packets
`timescale 1ns/1ps
`default_nettype none

module dma_packet_buffer
  import dma_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  wire   clk,
  input  wire   rst,
  input  flit_t in_flit,
  input  wire   in_valid,
  output logic  in_ready,
  output flit_t out_flit,
  output logic  out_valid,
  input  wire   out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flit storage
  flit_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Flits held
  logic [CNT_W-1:0] flit_cnt;
  // Complete packets held
  logic [CNT_W-1:0] pkt_cnt;

  logic wr_en;
  logic rd_en;
  logic wr_end;
  logic rd_end;

  assign in_ready = (flit_cnt != CNT_W'(DEPTH));
  // Only offer flits once a whole packet is inside
  assign out_valid = (pkt_cnt != '0);
  assign out_flit = mem[rd_ptr];

  assign wr_en = in_valid & in_ready;
  assign rd_en = out_valid & out_ready;
  assign wr_end = wr_en & flit_is_end(in_flit);
  assign rd_end = rd_en & flit_is_end(out_flit);

  ////////////////////
  // Storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  ////////////////////
  // Pointers and counters
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      flit_cnt <= '0;
      pkt_cnt <= '0;
    end else begin
      if (wr_en) begin
        // Wrap for depths that are not a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Fill level
      if (wr_en && !rd_en) begin
        flit_cnt <= flit_cnt + 1'b1;
      end else if (rd_en && !wr_en) begin
        flit_cnt <= flit_cnt - 1'b1;
      end
      // Packet boundary tracking
      if (wr_end && !rd_end) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end else if (rd_end && !wr_end) begin
        pkt_cnt <= pkt_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dma_write_ctrl.sv ====
// Write controller that decodes DMA requests and writes payload words over AHB
`timescale 1ns/1ps
`default_nettype none

module dma_write_ctrl
  import dma_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  flit_t      buf_flit,
  input  wire        buf_valid,
  output logic       buf_ready,
  output ahb_req_t   ahb_req,
  input  wire        ahb_hready,
  output logic       resp_push,
  output resp_info_t resp_info,
  input  wire        resp_full
);

  ctrl_state_t state;

  // Request parameters from the header
  tile_t      src_tile;
  packet_id_t pkt_id;
  logic       req_last;

  // Running word address
  addr_t addr;

  // Acknowledgement owed after the last word
  logic resp_pend;

  packet_type_t hdr_type;
  logic         flit_end;
  logic         word_take;
  logic         bus_sel;

  assign hdr_type = packet_type_t'(buf_flit[TYPE_MSB:TYPE_LSB]);
  assign flit_end = flit_is_end(buf_flit);

  // Bus request while payload is waiting
  assign bus_sel = (state == WRITE) && !resp_pend && buf_valid;
  assign word_take = bus_sel && ahb_hready;

  ////////////////////
  // Buffer and bus outputs
  always_comb begin
    case (state)
      IDLE:     buf_ready = 1'b1;
      GET_ADDR: buf_ready = 1'b1;
      WRITE:    buf_ready = word_take;
      DISCARD:  buf_ready = 1'b1;
      default:  buf_ready = 1'b0;
    endcase
  end

  // Single NONSEQ transfers with address and data together
  always_comb begin
    ahb_req.sel = bus_sel;
    ahb_req.write = bus_sel;
    ahb_req.trans = bus_sel ? HTRANS_NONSEQ : HTRANS_IDLE;
    ahb_req.addr = addr;
    ahb_req.wdata = buf_flit[DATA_WIDTH-1:0];
  end

  // Acknowledgement goes back to the requesting tile
  assign resp_push = (state == WRITE) && resp_pend && !resp_full;
  assign resp_info.dest = src_tile;
  assign resp_info.id = pkt_id;

  ////////////////////
  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      resp_pend <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (buf_valid) begin
            if (flit_end) begin
              // Lone header flit needs no work
              state <= IDLE;
            end else if (hdr_type == L2R_REQ) begin
              state <= GET_ADDR;
            end else begin
              state <= DISCARD;
            end
          end
        end
        GET_ADDR: begin
          if (buf_valid) begin
            // Packet without payload ends here
            state <= flit_end ? IDLE : WRITE;
          end
        end
        WRITE: begin
          if (resp_pend) begin
            // Hold until the queue has room
            if (!resp_full) begin
              resp_pend <= 1'b0;
              state <= IDLE;
            end
          end else if (word_take && flit_end) begin
            if (req_last) begin
              resp_pend <= 1'b1;
            end else begin
              state <= IDLE;
            end
          end
        end
        DISCARD: begin
          if (buf_valid && flit_end) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Request registers
  always_ff @(posedge clk) begin
    // Header capture
    if (state == IDLE && buf_valid) begin
      src_tile <= buf_flit[SRC_MSB:SRC_LSB];
      pkt_id <= buf_flit[ID_MSB:ID_LSB];
      req_last <= buf_flit[REQ_LAST_BIT];
    end
    // Start address then one word step per write
    if (state == GET_ADDR && buf_valid) begin
      addr <= buf_flit[ADDR_WIDTH-1:0];
    end else if (word_take) begin
      addr <= addr + addr_t'(4);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dma_resp_queue.sv ====
// Two-entry acknowledgement queue that builds single-flit responses for the NoC
`timescale 1ns/1ps
`default_nettype none

module dma_resp_queue
  import dma_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        push,
  input  resp_info_t info,
  output logic       full,
  output flit_t      out_flit,
  output logic       out_valid,
  input  wire        out_ready
);

  resp_info_t mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       pop;
  resp_info_t head;

  assign full = (count == 2'd2);
  assign out_valid = (count != 2'd0);
  assign pop = out_valid & out_ready;
  assign head = mem[rd_ptr];

  // Response flit from the head entry with unused bits zero
  always_comb begin
    out_flit = '0;
    out_flit[KIND_MSB:KIND_LSB] = SINGLE;
    out_flit[DEST_MSB:DEST_LSB] = head.dest;
    out_flit[CLASS_MSB:CLASS_LSB] = CLASS_DMA;
    out_flit[ID_MSB:ID_LSB] = head.id;
    out_flit[TYPE_MSB:TYPE_LSB] = L2R_RESP;
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[wr_ptr] <= info;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push && !full) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      if ((push && !full) && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !(push && !full)) begin
        count <= count - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dma_ahb_target.sv ====
// DMA target top level joining NoC input buffer, AHB write controller and response queue
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_target
  import dma_pkg::*;
#(
  parameter int NOC_PACKET_SIZE = 16
) (
  input  wire      clk,
  input  wire      rst,
  // NoC request side
  input  flit_t    noc_in_flit,
  input  wire      noc_in_valid,
  output logic     noc_in_ready,
  // NoC acknowledgement side
  output flit_t    noc_out_flit,
  output logic     noc_out_valid,
  input  wire      noc_out_ready,
  // AHB-Lite master
  output ahb_req_t ahb_req,
  input  wire      ahb_hready
);

  // Buffer to controller
  flit_t buf_flit;
  logic  buf_valid;
  logic  buf_ready;

  // Controller to queue
  logic       resp_push;
  resp_info_t resp_info;
  logic       resp_full;

  ////////////////////
  // Whole packets only past this point
  dma_packet_buffer #(
    .DEPTH (NOC_PACKET_SIZE)
  ) u_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dma_write_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .buf_flit   (buf_flit),
    .buf_valid  (buf_valid),
    .buf_ready  (buf_ready),
    .ahb_req    (ahb_req),
    .ahb_hready (ahb_hready),
    .resp_push  (resp_push),
    .resp_info  (resp_info),
    .resp_full  (resp_full)
  );

  // Decouples acknowledgements from NoC back-pressure
  dma_resp_queue u_resp (
    .clk       (clk),
    .rst       (rst),
    .push      (resp_push),
    .info      (resp_info),
    .full      (resp_full),
    .out_flit  (noc_out_flit),
    .out_valid (noc_out_valid),
    .out_ready (noc_out_ready)
  );

endmodule

`default_nettype wire

// ==== bench/tb_tasks.svh ====
// Packet sending, waits, checks and directed tests for the DMA target testbench

// Mismatch report and error count
task automatic check_value(input string name, input logic [63:0] expected,
    input logic [63:0] actual);
  checks++;
  if (actual !== expected) begin
    $display("error %s expected %0h actual %0h", name, expected, actual);
    errors++;
  end
endtask

// Request header of kind HEADER in class DMA
function automatic flit_t build_header(input tile_t src, input packet_id_t id,
    input logic [1:0] ptype, input logic req_last);
  flit_t f;
  f = '0;
  f[33:32] = 2'd1;
  f[31:27] = TARGET_TILE;
  f[26:24] = 3'd2;
  f[23:20] = id;
  f[19:15] = src;
  f[14:13] = ptype;
  f[12] = req_last;
  return f;
endfunction

// Expected acknowledgement of kind SINGLE and type L2R_RESP
function automatic flit_t build_ack(input tile_t dest, input packet_id_t id);
  flit_t f;
  f = '0;
  f[33:32] = 2'd3;
  f[31:27] = dest;
  f[26:24] = 3'd2;
  f[23:20] = id;
  f[14:13] = 2'd1;
  return f;
endfunction

// Runs from just after a rising edge up to the edge that takes the flit
task automatic send_flit(input flit_t f);
  int waited;
  noc_in_flit <= f;
  noc_in_valid <= 1'b1;
  waited = 0;
  @(negedge clk);
  while (!noc_in_ready && waited < TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (!noc_in_ready) begin
    $display("NoC input did not accept a flit within %0d cycles", TIMEOUT);
    errors++;
  end
  @(posedge clk);
endtask

// Header, start address, then n words counting up from base
task automatic send_packet(input tile_t src, input packet_id_t id, input logic [1:0] ptype,
    input logic req_last, input addr_t addr, input data_t base, input int n);
  logic [1:0] kind;
  int k;
  @(posedge clk);
  send_flit(build_header(src, id, ptype, req_last));
  send_flit({2'd0, addr});
  for (k = 0; k < n; k++) begin
    kind = (k == n - 1) ? 2'd2 : 2'd0;
    send_flit({kind, base + data_t'(k)});
  end
  noc_in_valid <= 1'b0;
endtask

task automatic wait_writes(input int n);
  int waited;
  waited = 0;
  while (log_addr.size() < n && waited < TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (log_addr.size() < n) begin
    $display("Memory saw %0d of %0d writes before the timeout", log_addr.size(), n);
    errors++;
  end
endtask

task automatic wait_acks(input int n);
  int waited;
  waited = 0;
  while (ack_q.size() < n && waited < TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (ack_q.size() < n) begin
    $display("Only %0d of %0d acknowledgements arrived before the timeout", ack_q.size(), n);
    errors++;
  end
endtask

// Quiet window to catch stray writes or acknowledgements
task automatic drain();
  repeat (DRAIN) @(negedge clk);
endtask

task automatic check_block(input string name, input addr_t addr, input data_t base,
    input int n);
  addr_t a;
  int k;
  for (k = 0; k < n; k++) begin
    a = addr + addr_t'(4 * k);
    if (!mem_model.exists(a)) begin
      $display("No write reached address %h in %s", a, name);
      errors++;
    end else begin
      check_value($sformatf("%s word %0d", name, k), 64'(base + data_t'(k)),
                  64'(mem_model[a]));
    end
  end
endtask

////////////////////
// Directed tests
task automatic test_single_write();
  int log_start;
  int ack_start;
  log_start = log_addr.size();
  ack_start = ack_q.size();
  send_packet(5'd5, 4'd3, 2'd0, 1'b1, 32'h0000_1000, 32'hA100_0000, 4);
  wait_writes(log_start + 4);
  wait_acks(ack_start + 1);
  drain();
  check_block("single_write", 32'h0000_1000, 32'hA100_0000, 4);
  check_value("single_write ack count", 64'd1, 64'(ack_q.size() - ack_start));
  if (ack_q.size() > ack_start) begin
    check_value("single_write ack", 64'(build_ack(5'd5, 4'd3)), 64'(ack_q[ack_start]));
  end
endtask

// First packet without the flag and second with it
task automatic test_multi_packet();
  int log_start;
  int ack_start;
  log_start = log_addr.size();
  ack_start = ack_q.size();
  send_packet(5'd7, 4'd6, 2'd0, 1'b0, 32'h0000_2000, 32'hB200_0000, 3);
  send_packet(5'd7, 4'd7, 2'd0, 1'b1, 32'h0000_3000, 32'hB300_0000, 2);
  wait_writes(log_start + 5);
  wait_acks(ack_start + 1);
  drain();
  check_block("multi_packet first", 32'h0000_2000, 32'hB200_0000, 3);
  check_block("multi_packet second", 32'h0000_3000, 32'hB300_0000, 2);
  check_value("multi_packet ack count", 64'd1, 64'(ack_q.size() - ack_start));
  if (ack_q.size() > ack_start) begin
    check_value("multi_packet ack", 64'(build_ack(5'd7, 4'd7)), 64'(ack_q[ack_start]));
  end
endtask

task automatic test_wait_states();
  int log_start;
  int k;
  log_start = log_addr.size();
  @(posedge clk);
  stall_en <= 1'b1;
  send_packet(5'd3, 4'd9, 2'd0, 1'b1, 32'h0000_4000, 32'hC400_0000, 12);
  wait_writes(log_start + 12);
  drain();
  @(posedge clk);
  stall_en <= 1'b0;
  // Log must be exactly the twelve words in address order
  check_value("wait_states write count", 64'd12, 64'(log_addr.size() - log_start));
  for (k = 0; k < 12 && log_start + k < log_addr.size(); k++) begin
    check_value($sformatf("wait_states addr %0d", k),
                64'(32'h0000_4000 + 32'(4 * k)), 64'(log_addr[log_start + k]));
    check_value($sformatf("wait_states data %0d", k),
                64'(32'hC400_0000 + 32'(k)), 64'(log_data[log_start + k]));
  end
endtask

task automatic test_discard();
  int log_start;
  int ack_start;
  log_start = log_addr.size();
  ack_start = ack_q.size();
  // Read request of type R2L_REQ
  send_packet(5'd9, 4'd1, 2'd2, 1'b1, 32'h0000_6000, 32'hE600_0000, 3);
  drain();
  check_value("discard write count", 64'd0, 64'(log_addr.size() - log_start));
  check_value("discard ack count", 64'd0, 64'(ack_q.size() - ack_start));
  send_packet(5'd9, 4'd2, 2'd0, 1'b1, 32'h0000_7000, 32'hE700_0000, 2);
  wait_writes(log_start + 2);
  wait_acks(ack_start + 1);
  drain();
  check_block("discard follow_up", 32'h0000_7000, 32'hE700_0000, 2);
  check_value("discard follow_up ack count", 64'd1, 64'(ack_q.size() - ack_start));
  if (ack_q.size() > ack_start) begin
    check_value("discard follow_up ack", 64'(build_ack(5'd9, 4'd2)), 64'(ack_q[ack_start]));
  end
endtask

// Queue holds two, controller one more, fourth waits in the buffer
task automatic test_back_pressure();
  int log_start;
  int ack_start;
  int i;
  log_start = log_addr.size();
  ack_start = ack_q.size();
  @(posedge clk);
  noc_out_ready <= 1'b0;
  for (i = 0; i < 4; i++) begin
    send_packet(5'd12, packet_id_t'(8 + i), 2'd0, 1'b1, 32'h0000_8000 + addr_t'(256 * i),
                32'hF000_0000 + data_t'(32'h0010_0000 * i), 3);
  end
  wait_writes(log_start + 9);
  drain();
  check_value("back_pressure stalled writes", 64'd9, 64'(log_addr.size() - log_start));
  // First acknowledgement stays offered while the sink refuses it
  check_value("back_pressure held valid", 64'd1, 64'(noc_out_valid));
  check_value("back_pressure held ack", 64'(build_ack(5'd12, 4'd8)), 64'(noc_out_flit));
  @(posedge clk);
  noc_out_ready <= 1'b1;
  wait_writes(log_start + 12);
  wait_acks(ack_start + 4);
  drain();
  check_value("back_pressure ack count", 64'd4, 64'(ack_q.size() - ack_start));
  for (i = 0; i < 4; i++) begin
    check_block($sformatf("back_pressure block %0d", i), 32'h0000_8000 + addr_t'(256 * i),
                32'hF000_0000 + data_t'(32'h0010_0000 * i), 3);
    if (ack_start + i < ack_q.size()) begin
      check_value($sformatf("back_pressure ack %0d", i),
                  64'(build_ack(5'd12, packet_id_t'(8 + i))), 64'(ack_q[ack_start + i]));
    end
  end
endtask

// ==== bench/tb_dma_target.sv ====
// Testbench for the DMA target with AHB memory model, acknowledgement sink and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_dma_target
  import dma_pkg::*;
();

  localparam int TIMEOUT = 2000;
  localparam int DRAIN = 20;
  localparam tile_t TARGET_TILE = 5'd1;

  logic     clk = 1'b0;
  logic     rst;
  flit_t    noc_in_flit;
  logic     noc_in_valid;
  logic     noc_in_ready;
  flit_t    noc_out_flit;
  logic     noc_out_valid;
  logic     noc_out_ready;
  ahb_req_t ahb_req;
  logic     ahb_hready = 1'b1;

  // Random wait states on or off
  logic   stall_en;
  integer seed = 82996;

  // Memory contents and write history
  data_t mem_model [addr_t];
  addr_t log_addr [$];
  data_t log_data [$];
  // Every acknowledgement flit seen on the NoC output
  flit_t ack_q [$];

  int errors;
  int checks;
  int bus_errors = 0;

  always #50 clk = ~clk;

  dma_ahb_target #(
    .NOC_PACKET_SIZE (16)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .ahb_req       (ahb_req),
    .ahb_hready    (ahb_hready)
  );

  ////////////////////
  // AHB memory model
  always @(posedge clk) begin
    if (ahb_req.sel && ahb_hready) begin
      // Only single NONSEQ writes expected
      if (!ahb_req.write || ahb_req.trans != 2'b10) begin
        $display("AHB transfer at address %h was not a NONSEQ write", ahb_req.addr);
        bus_errors++;
      end
      mem_model[ahb_req.addr] = ahb_req.wdata;
      log_addr.push_back(ahb_req.addr);
      log_data.push_back(ahb_req.wdata);
    end
    // Roughly one stall cycle in four
    ahb_hready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // NoC acknowledgement sink
  always @(posedge clk) begin
    if (noc_out_valid && noc_out_ready) begin
      ack_q.push_back(noc_out_flit);
    end
  end

  `include "tb_tasks.svh"

  ////////////////////
  // Test sequence
  initial begin
    rst = 1'b1;
    noc_in_flit = '0;
    noc_in_valid = 1'b0;
    noc_out_ready = 1'b1;
    stall_en = 1'b0;
    errors = 0;
    checks = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // Idle outputs out of reset
    check_value("reset noc_out_valid", 64'd0, 64'(noc_out_valid));
    check_value("reset ahb sel", 64'd0, 64'(ahb_req.sel));
    check_value("reset noc_in_ready", 64'd1, 64'(noc_in_ready));
    test_single_write();
    test_multi_packet();
    test_wait_states();
    test_discard();
    test_back_pressure();
    errors = errors + bus_errors;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
verilog/dma_pkg.sv
verilog/dma_packet_buffer.sv
verilog/dma_write_ctrl.sv
verilog/dma_resp_queue.sv
verilog/dma_ahb_target.sv
bench/tb_dma_target.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA target testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
  --top-module tb_dma_target --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
